// File: yreg_unit.f
+incdir+common
common/yreg_pkg.sv
design/yreg_op_decode.sv
yreg_file/yreg_file.sv
design/yreg_mulstep.sv
design/yreg_result.sv
design/yreg_unit_top.sv
verification/yreg_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Y-register unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wall -Wno-fatal \
   -f yreg_unit.f --top-module yreg_unit_tb -o yreg_unit_sim
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/yreg_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
   echo "Simulation ended without a verdict"
   exit 1
fi

exit 0

// File: verification/yreg_unit_tb.sv
`timescale 1ns/1ps
`include "yreg_defs.svh"

module yreg_unit_tb;

   //////////////////////////////////////////////////
   // Run length, in clock cycles
   //////////////////////////////////////////////////

   localparam int RESET_CYC = 12;
   localparam int T1_CYC    = 20;
   localparam int T2_CYC    = 45;
   localparam int T3_CYC    = 40;
   localparam int T4_CYC    = 120;
   localparam int T5_CYC    = 40;
   localparam int CYC_LIMIT = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + 50;
   localparam int NPEND     = 8;

   logic                  clk;
   logic                  rst_n;
   logic                  op_valid;
   yreg_pkg::yreg_op_e    op;
   yreg_pkg::yreg_thr_t   thr;
   logic [`YREG_W-1:0]    rs1;
   logic [`YREG_W-1:0]    rs2;
   logic                  res_valid;
   yreg_pkg::yreg_thr_t   res_thr;
   logic [`YREG_W-1:0]    res_data;

   // Reference Y per thread
   logic [`YREG_W-1:0]    model_y [`YREG_NTHR];

   // Pending Y writes, counted down in edges
   int                    pend_cnt  [NPEND];
   yreg_pkg::yreg_op_e    pend_op   [NPEND];
   yreg_pkg::yreg_thr_t   pend_thr  [NPEND];
   logic [`YREG_W-1:0]    pend_data [NPEND];

   // Expected results in issue order
   logic [`YREG_W-1:0]    exp_data [$];
   yreg_pkg::yreg_thr_t   exp_thr  [$];
   // Cycle in which each result strobe is due
   int                    exp_cyc  [$];

   logic [31:0]           lfsr;
   int                    cycles;
   int                    data_errs;
   int                    thr_errs;
   int                    proto_errs;

   yreg_unit_top dut0 (
      .clk(clk), .rst_n(rst_n), .op_valid(op_valid), .op(op), .thr(thr),
      .rs1(rs1), .rs2(rs2), .res_valid(res_valid), .res_thr(res_thr),
      .res_data(res_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   // Galois LFSR, one step per bit
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic rand_word(output logic [`YREG_W-1:0] w);
      for (int i = 0; i < `YREG_W; i++) begin
         lfsr = lfsr_step(lfsr);
         w[i] = lfsr[0];
      end
   endtask

   task automatic check_data(input logic [`YREG_W-1:0] got, input logic [`YREG_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         data_errs++;
         $display("CHECK FAILED at %0t: %s data %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_thr(input yreg_pkg::yreg_thr_t got, input yreg_pkg::yreg_thr_t exp);
      if (got !== exp) begin
         thr_errs++;
         $display("CHECK FAILED at %0t: result thread %0d expected %0d", $time, got, exp);
      end
   endtask

   // Model Y writes land on the counted edge
   always @(posedge clk) begin
      for (int k = 0; k < NPEND; k++) begin
         if (pend_cnt[k] > 0) begin
            pend_cnt[k]--;
            if (pend_cnt[k] == 0) begin
               if (pend_op[k] == yreg_pkg::OP_MULSCC)
                  model_y[pend_thr[k]] = {pend_data[k][0], model_y[pend_thr[k]][`YREG_W-1:1]};
               else
                  model_y[pend_thr[k]] = pend_data[k];
            end
         end
      end
   end

   task automatic add_pending(input yreg_pkg::yreg_op_e o, input yreg_pkg::yreg_thr_t t,
                              input logic [`YREG_W-1:0] d, input int n);
      int slot;
      slot = -1;
      for (int k = 0; k < NPEND; k++) begin
         if (slot < 0 && pend_cnt[k] == 0) slot = k;
      end
      pend_cnt[slot]  = n;
      pend_op[slot]   = o;
      pend_thr[slot]  = t;
      pend_data[slot] = d;
   endtask

   // Issue one op, queue its result and its Y write
   task automatic issue(input yreg_pkg::yreg_op_e o, input yreg_pkg::yreg_thr_t t,
                        input logic [`YREG_W-1:0] a, input logic [`YREG_W-1:0] b,
                        output logic [`YREG_W-1:0] rd);
      logic [2*`YREG_W-1:0] prod;
      @(posedge clk);
      #1;
      prod = {32'd0, a} * {32'd0, b};
      rd = '0;
      case (o)
         yreg_pkg::OP_WRY: add_pending(o, t, a ^ b, 2);
         yreg_pkg::OP_RDY: rd = model_y[t];
         yreg_pkg::OP_MULSCC: begin
            rd = (a >> 1) + (model_y[t][0] ? b : '0);
            add_pending(o, t, a, 3);
         end
         default: begin
            rd = prod[`YREG_W-1:0];
            add_pending(o, t, prod[2*`YREG_W-1:`YREG_W], 3);
         end
      endcase
      if (o != yreg_pkg::OP_WRY) begin
         exp_data.push_back(rd);
         exp_thr.push_back(t);
         // Result strobe follows the second edge after E
         exp_cyc.push_back(cycles + 2);
      end
      op_valid = 1'b1;
      op       = o;
      thr      = t;
      rs1      = a;
      rs2      = b;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         op_valid = 1'b0;
      end
   endtask

   // Results compared mid-cycle where outputs are stable
   always @(negedge clk) begin
      if (rst_n && res_valid) begin
         if (exp_data.size() == 0) begin
            proto_errs++;
            $display("Unexpected result strobe at %0t with no op outstanding", $time);
         end else begin
            if (cycles != exp_cyc[0]) begin
               proto_errs++;
               $display("Result strobe at %0t came in cycle %0d, expected in cycle %0d",
                        $time, cycles, exp_cyc[0]);
            end
            exp_cyc.delete(0);
            check_data(res_data, exp_data.pop_front(), "result");
            check_thr(res_thr, exp_thr.pop_front());
         end
      end
   end

   task automatic drain;
      int n;
      n = 0;
      idle(1);
      while (exp_data.size() != 0 && n < 8) begin
         idle(1);
         n++;
      end
      if (exp_data.size() != 0) begin
         proto_errs++;
         $display("Missing result strobe, %0d results never came back", exp_data.size());
         exp_data.delete();
         exp_thr.delete();
         exp_cyc.delete();
      end
      idle(3);
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic test_reset_read;
      logic [`YREG_W-1:0] rd;
      for (int t = 0; t < `YREG_NTHR; t++) begin
         issue(yreg_pkg::OP_RDY, t, '0, '0, rd);
      end
      drain();
   endtask

   task automatic test_wry_rdy;
      logic [`YREG_W-1:0] a;
      logic [`YREG_W-1:0] b;
      logic [`YREG_W-1:0] rd;
      for (int t = 0; t < `YREG_NTHR; t++) begin
         rand_word(a);
         rand_word(b);
         issue(yreg_pkg::OP_WRY, t, a, b, rd);
         idle(2);
         issue(yreg_pkg::OP_RDY, t, '0, '0, rd);
         check_data(rd, a ^ b, "model Y after WRY");
         idle(2);
      end
      // Each thread keeps its own value
      for (int t = 0; t < `YREG_NTHR; t++) begin
         issue(yreg_pkg::OP_RDY, t, '0, '0, rd);
      end
      drain();
   endtask

   task automatic test_umul;
      logic [`YREG_W-1:0] a;
      logic [`YREG_W-1:0] b;
      logic [`YREG_W-1:0] rd;
      for (int t = 0; t < `YREG_NTHR; t++) begin
         rand_word(a);
         rand_word(b);
         issue(yreg_pkg::OP_UMUL, t, a, b, rd);
         idle(2);
         issue(yreg_pkg::OP_RDY, t, '0, '0, rd);
         idle(2);
      end
      drain();
   endtask

   // Shift-before-add steps leave twice the product in {rd, Y}
   task automatic test_mulscc;
      logic [`YREG_W-1:0]   mcand;
      logic [`YREG_W-1:0]   mplier;
      logic [`YREG_W-1:0]   p;
      logic [`YREG_W-1:0]   rd;
      logic [2*`YREG_W-1:0] full;
      rand_word(mcand);
      rand_word(mplier);
      mcand = mcand & 32'h7fffffff;
      issue(yreg_pkg::OP_WRY, 2'd1, mplier, '0, rd);
      idle(2);
      p = '0;
      for (int s = 0; s < 32; s++) begin
         issue(yreg_pkg::OP_MULSCC, 2'd1, p, mcand, p);
         idle(2);
      end
      issue(yreg_pkg::OP_RDY, 2'd1, '0, '0, rd);
      full = ({32'd0, mcand} * {32'd0, mplier}) << 1;
      check_data(p, full[2*`YREG_W-1:`YREG_W], "step product high");
      check_data(rd, full[`YREG_W-1:0], "step product low in Y");
      drain();
   endtask

   task automatic test_back_to_back;
      logic [`YREG_W-1:0] a;
      logic [`YREG_W-1:0] b;
      logic [`YREG_W-1:0] rd;
      rand_word(a);
      rand_word(b);
      // UMUL on 1 and WRY on 0 write Y on the same edge
      issue(yreg_pkg::OP_UMUL, 2'd1, a, b, rd);
      issue(yreg_pkg::OP_WRY, 2'd0, b, 32'h0f0f_1234, rd);
      issue(yreg_pkg::OP_RDY, 2'd2, '0, '0, rd);
      issue(yreg_pkg::OP_MULSCC, 2'd3, a, b, rd);
      issue(yreg_pkg::OP_RDY, 2'd1, '0, '0, rd);
      idle(3);
      for (int t = 0; t < `YREG_NTHR; t++) begin
         issue(yreg_pkg::OP_RDY, t, '0, '0, rd);
      end
      drain();
   endtask

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYC_LIMIT) begin
         $display("Timeout, run did not finish within %0d cycles", CYC_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      rst_n      = 1'b0;
      op_valid   = 1'b0;
      op         = yreg_pkg::OP_WRY;
      thr        = '0;
      rs1        = '0;
      rs2        = '0;
      lfsr       = 32'h5170;
      cycles     = 0;
      data_errs  = 0;
      thr_errs   = 0;
      proto_errs = 0;
      for (int t = 0; t < `YREG_NTHR; t++) model_y[t] = '0;
      for (int k = 0; k < NPEND; k++) pend_cnt[k] = 0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      idle(1);
      test_reset_read();
      test_wry_rdy();
      test_umul();
      test_mulscc();
      test_back_to_back();
      $display("Errors: data %0d, thread %0d, strobe %0d", data_errs, thr_errs, proto_errs);
      if (data_errs + thr_errs + proto_errs == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: design/yreg_unit_top.sv
`timescale 1ns/1ps
`include "yreg_defs.svh"

module yreg_unit_top (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     op_valid,
   input  yreg_pkg::yreg_op_e       op,
   input  yreg_pkg::yreg_thr_t      thr,
   input  logic [`YREG_W-1:0]       rs1,
   input  logic [`YREG_W-1:0]       rs2,
   output logic                     res_valid,
   output yreg_pkg::yreg_thr_t      res_thr,
   output logic [`YREG_W-1:0]       res_data
);

   // Decoder outputs
   logic [`YREG_NTHR-1:0] thr_e_oh;
   logic [`YREG_NTHR-1:0] wen_w;
   logic [`YREG_NTHR-1:0] wen_g;
   logic [`YREG_NTHR-1:0] shift_g;
   logic [`YREG_NTHR-1:0] wen_l;
   logic                  valid_m;
   yreg_pkg::yreg_op_e    op_m;
   yreg_pkg::yreg_thr_t   thr_m;

   // Data paths
   logic [`YREG_W-1:0]    wry_data_w;
   logic [`YREG_W-1:0]    y_e;
   logic [`YREG_W-1:0]    y_e_d;
   logic [`YREG_W-1:0]    mul_rd_m;
   logic [`YREG_W-1:0]    mul_y_g;
   logic                  shift_bit_g;

   //////////////////////////////////////////////////
   // Local data
   //////////////////////////////////////////////////

   // WRY value, staged to W inside the file
   assign wry_data_w = rs1 ^ rs2;

   // Y of the issuing thread, held into M for RDY
   always_ff @(posedge clk) begin
      y_e_d <= y_e;
   end

   //////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////

   yreg_op_decode u_decode (
      .clk(clk), .rst_n(rst_n), .op_valid(op_valid), .op(op), .thr(thr),
      .thr_e_oh(thr_e_oh), .wen_w(wen_w), .wen_g(wen_g), .shift_g(shift_g),
      .wen_l(wen_l), .valid_m(valid_m), .op_m(op_m), .thr_m(thr_m)
   );

   yreg_file u_file (
      .clk(clk), .rst_n(rst_n), .thr_e_oh(thr_e_oh), .wry_data_w(wry_data_w),
      .mul_y_g(mul_y_g), .shift_bit_g(shift_bit_g), .wen_w(wen_w), .wen_g(wen_g),
      .wen_l(wen_l), .shift_g(shift_g), .y_e(y_e)
   );

   yreg_mulstep u_mulstep (
      .clk(clk), .rst_n(rst_n), .op_valid(op_valid), .op(op), .rs1(rs1), .rs2(rs2),
      .y_e(y_e), .mul_rd_m(mul_rd_m), .mul_y_g(mul_y_g), .shift_bit_g(shift_bit_g)
   );

   yreg_result u_result (
      .clk(clk), .rst_n(rst_n), .valid_m(valid_m), .op_m(op_m), .thr_m(thr_m),
      .mul_rd_m(mul_rd_m), .y_e_d(y_e_d), .res_valid(res_valid), .res_thr(res_thr),
      .res_data(res_data)
   );

endmodule

// File: design/yreg_result.sv
`timescale 1ns/1ps
`include "yreg_defs.svh"

module yreg_result (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     valid_m,
   input  yreg_pkg::yreg_op_e       op_m,
   input  yreg_pkg::yreg_thr_t      thr_m,
   input  logic [`YREG_W-1:0]       mul_rd_m,
   input  logic [`YREG_W-1:0]       y_e_d,
   output logic                     res_valid,
   output yreg_pkg::yreg_thr_t      res_thr,
   output logic [`YREG_W-1:0]       res_data
);

   // Selected result in M
   logic [`YREG_W-1:0] res_sel_m;

   // WRY only writes Y
   logic               res_v_m;

   //////////////////////////////////////////////////
   // Result select
   //////////////////////////////////////////////////

   // RDY returns the Y read in E, others the multiply rd
   assign res_sel_m = (op_m == yreg_pkg::OP_RDY) ? y_e_d : mul_rd_m;
   assign res_v_m   = valid_m && (op_m != yreg_pkg::OP_WRY);

   //////////////////////////////////////////////////
   // Output register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= res_v_m;
      end
   end

   always_ff @(posedge clk) begin
      res_thr  <= thr_m;
      res_data <= res_sel_m;
   end

endmodule

// File: design/yreg_mulstep.sv
`timescale 1ns/1ps
`include "yreg_defs.svh"

module yreg_mulstep (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     op_valid,
   input  yreg_pkg::yreg_op_e       op,
   input  logic [`YREG_W-1:0]       rs1,
   input  logic [`YREG_W-1:0]       rs2,
   input  logic [`YREG_W-1:0]       y_e,
   output logic [`YREG_W-1:0]       mul_rd_m,
   output logic [`YREG_W-1:0]       mul_y_g,
   output logic                     shift_bit_g
);

   // E stage results
   logic [`YREG_W-1:0]   step_sum_e;
   logic [2*`YREG_W-1:0] prod_e;
   logic                 is_mulscc_e;
   logic                 mul_e;

   // M stage carry to G
   logic                 mul_v_m;
   logic [`YREG_W-1:0]   prod_hi_m;
   logic                 rs1_lsb_m;

   //////////////////////////////////////////////////
   // E stage arithmetic
   //////////////////////////////////////////////////

   assign is_mulscc_e = (op == yreg_pkg::OP_MULSCC);
   assign mul_e       = op_valid && (is_mulscc_e || (op == yreg_pkg::OP_UMUL));

   // Multiply step
   // Partial product in rs1 shifts down, rs2 added when Y bit 0 is set
   // No condition codes, so a zero enters at the top
   assign step_sum_e = {1'b0, rs1[`YREG_W-1:1]} + (rs2 & {`YREG_W{y_e[0]}});

   // Full unsigned product
   assign prod_e = {{`YREG_W{1'b0}}, rs1} * {{`YREG_W{1'b0}}, rs2};

   //////////////////////////////////////////////////
   // E to M
   //////////////////////////////////////////////////

   // Stage valid, used to load the G registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mul_v_m <= 1'b0;
      end else begin
         mul_v_m <= mul_e;
      end
   end

   // Rd value goes to the result stage in M
   always_ff @(posedge clk) begin
      if (mul_e) begin
         mul_rd_m  <= is_mulscc_e ? step_sum_e : prod_e[`YREG_W-1:0];
         prod_hi_m <= prod_e[2*`YREG_W-1:`YREG_W];
         // Bit shifted into Y on a multiply step
         rs1_lsb_m <= rs1[0];
      end
   end

   //////////////////////////////////////////////////
   // M to G
   //////////////////////////////////////////////////

   // Y write data for the G path
   always_ff @(posedge clk) begin
      if (mul_v_m) begin
         mul_y_g     <= prod_hi_m;
         shift_bit_g <= rs1_lsb_m;
      end
   end

endmodule

// File: yreg_file/yreg_file.sv
`timescale 1ns/1ps
`include "yreg_defs.svh"

module yreg_file (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`YREG_NTHR-1:0]    thr_e_oh,
   input  logic [`YREG_W-1:0]       wry_data_w,
   input  logic [`YREG_W-1:0]       mul_y_g,
   input  logic                     shift_bit_g,
   input  logic [`YREG_NTHR-1:0]    wen_w,
   input  logic [`YREG_NTHR-1:0]    wen_g,
   input  logic [`YREG_NTHR-1:0]    wen_l,
   input  logic [`YREG_NTHR-1:0]    shift_g,
   output logic [`YREG_W-1:0]       y_e
);

   // WRY data delayed to line up with wen_w
   logic [`YREG_W-1:0] w2_data;

   // Current and next Y per thread
   logic [`YREG_W-1:0] y_q    [`YREG_NTHR];
   logic [`YREG_W-1:0] y_next [`YREG_NTHR];

   //////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////

   // One-hot AND-OR mux on the issuing thread
   always_comb begin
      y_e = '0;
      for (int t = 0; t < `YREG_NTHR; t++) begin
         y_e = y_e | ({`YREG_W{thr_e_oh[t]}} & y_q[t]);
      end
   end

   //////////////////////////////////////////////////
   // Write data alignment
   //////////////////////////////////////////////////

   // E data captured so it is stable during W
   always_ff @(posedge clk) begin
      w2_data <= wry_data_w;
   end

   //////////////////////////////////////////////////
   // Next value select
   //////////////////////////////////////////////////

   // Four one-hot sources per thread
   //   w2 data, G multiply data, hold, shift right
   always_comb begin
      for (int t = 0; t < `YREG_NTHR; t++) begin
         y_next[t] = ({`YREG_W{wen_w[t]}}   & w2_data)
                   | ({`YREG_W{wen_g[t]}}   & mul_y_g)
                   | ({`YREG_W{wen_l[t]}}   & y_q[t])
                   | ({`YREG_W{shift_g[t]}} & {shift_bit_g, y_q[t][`YREG_W-1:1]});
      end
   end

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int t = 0; t < `YREG_NTHR; t++) begin
            y_q[t] <= '0;
         end
      end else begin
         for (int t = 0; t < `YREG_NTHR; t++) begin
            y_q[t] <= y_next[t];
         end
      end
   end

endmodule

// File: design/yreg_op_decode.sv
`timescale 1ns/1ps
`include "yreg_defs.svh"

module yreg_op_decode (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     op_valid,
   input  yreg_pkg::yreg_op_e       op,
   input  yreg_pkg::yreg_thr_t      thr,
   output logic [`YREG_NTHR-1:0]    thr_e_oh,
   output logic [`YREG_NTHR-1:0]    wen_w,
   output logic [`YREG_NTHR-1:0]    wen_g,
   output logic [`YREG_NTHR-1:0]    shift_g,
   output logic [`YREG_NTHR-1:0]    wen_l,
   output logic                     valid_m,
   output yreg_pkg::yreg_op_e       op_m,
   output yreg_pkg::yreg_thr_t      thr_m
);

   // Thread one-hot for the op now in M
   logic [`YREG_NTHR-1:0] thr_m_oh;

   // Op class flags in E and M
   logic                  is_wry_e;
   logic                  is_umul_m;
   logic                  is_mulscc_m;

   //////////////////////////////////////////////////
   // E stage decode
   //////////////////////////////////////////////////

   // Read select for the Y file mux
   always_comb begin
      thr_e_oh      = '0;
      thr_e_oh[thr] = 1'b1;
   end

   // WRY goes down the late write path
   assign is_wry_e = op_valid && (op == yreg_pkg::OP_WRY);

   //////////////////////////////////////////////////
   // E to M (W) pipeline
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_m <= 1'b0;
         op_m    <= yreg_pkg::OP_WRY;
         thr_m   <= '0;
         wen_w   <= '0;
      end else begin
         valid_m <= op_valid;
         op_m    <= op;
         thr_m   <= thr;
         // W write lands on the next edge, the second after E
         wen_w   <= is_wry_e ? thr_e_oh : '0;
      end
   end

   //////////////////////////////////////////////////
   // M stage decode
   //////////////////////////////////////////////////

   always_comb begin
      thr_m_oh        = '0;
      thr_m_oh[thr_m] = 1'b1;
   end

   // Multiply ops write Y from the G stage
   assign is_umul_m   = valid_m && (op_m == yreg_pkg::OP_UMUL);
   assign is_mulscc_m = valid_m && (op_m == yreg_pkg::OP_MULSCC);

   //////////////////////////////////////////////////
   // M to G pipeline
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wen_g   <= '0;
         shift_g <= '0;
      end else begin
         // UMUL loads the high product half
         wen_g   <= is_umul_m ? thr_m_oh : '0;
         // MULSCC shifts Y right by one
         shift_g <= is_mulscc_m ? thr_m_oh : '0;
      end
   end

   // Hold each thread that sees no write source this cycle
   // Issuer keeps W and G writes on different threads
   assign wen_l = ~(wen_w | wen_g | shift_g);

endmodule

// File: common/yreg_pkg.sv
`include "yreg_defs.svh"

package yreg_pkg;

   //////////////////////////////////////////////////
   // Operation encoding
   //////////////////////////////////////////////////

   // Ops accepted by the Y-register block
   typedef enum logic [1:0] {
      OP_WRY    = 2'd0,
      OP_RDY    = 2'd1,
      OP_MULSCC = 2'd2,
      OP_UMUL   = 2'd3
   } yreg_op_e;

   //////////////////////////////////////////////////
   // Thread identification
   //////////////////////////////////////////////////

   // Binary thread id, travels with the op down the pipe
   typedef logic [`YREG_TW-1:0] yreg_thr_t;

endpackage

// File: common/yreg_defs.svh
`ifndef YREG_DEFS_SVH
`define YREG_DEFS_SVH

// Number of hardware threads sharing the unit
`define YREG_NTHR 4

// Data path width of rs1, rs2 and each Y register
`define YREG_W 32

// Thread id width, log2 of the thread count
`define YREG_TW 2

`endif
